//--- sources.f
src/core_isa_pkg.sv
src/core_if_pkg.sv
src/core_fifo.sv
src/core_fe.sv
src/core_be_decode.sv
src/core_be_execute.sv
src/core_be_result.sv
src/core_top.sv
test/core_chk.sv
test/core_tb.sv

//--- Bender.yml
package:
  name: core

sources:
  - src/core_isa_pkg.sv
  - src/core_if_pkg.sv
  - src/core_fifo.sv
  - src/core_fe.sv
  - src/core_be_decode.sv
  - src/core_be_execute.sv
  - src/core_be_result.sv
  - src/core_top.sv
  - target: test
    files:
      - test/core_chk.sv
      - test/core_tb.sv

//--- test/core_tb.sv
// testbench for core_top with a random program ROM, an ISA reference model and commit checks
`timescale 1ns/1ps

module core_tb
    import core_isa_pkg::*;
();

    localparam int commits_per_run = 800;
    localparam int commit_timeout  = 64;
    localparam int reset_cycles    = 8;

    logic                      clk;
    logic                      reset;
    logic [pc_width-1:0]       imem_addr;
    logic [instr_width-1:0]    imem_data;
    logic                      cmt_v;
    logic [pc_width-1:0]       cmt_pc;
    logic                      cmt_rd_w_v;
    logic [reg_addr_width-1:0] cmt_rd_addr;
    logic [xlen-1:0]           cmt_data;

    logic [instr_width-1:0] rom [2 ** pc_width];
    logic [xlen-1:0]        model_rf [num_regs];
    logic [pc_width-1:0]    model_pc;

    assign imem_data = rom[imem_addr];   // same-cycle instruction memory

    core_top u_dut (
        .clk_i        (clk),
        .reset_i      (reset),
        .imem_addr_o  (imem_addr),
        .imem_data_i  (imem_data),
        .cmt_v_o      (cmt_v),
        .cmt_pc_o     (cmt_pc),
        .cmt_rd_w_v_o (cmt_rd_w_v),
        .cmt_rd_addr_o(cmt_rd_addr),
        .cmt_data_o   (cmt_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [reg_addr_width-1:0] pick_reg();
        if ($urandom_range(99, 0) < 75) return 3'($urandom_range(3, 0));   // favour r0..r3
        else return 3'($urandom_range(7, 4));
    endfunction

    function automatic logic [4:0] branch_offset();
        if ($urandom_range(99, 0) < 80) return 5'($urandom_range(15, 0));
        else return 5'(32 - $urandom_range(16, 2));   // backward, never a self loop
    endfunction

    function automatic logic [instr_width-1:0] make_instr();
        int unsigned            sel;
        logic [2:0]             op;
        logic [instr_width-1:0] instr;
        sel = $urandom_range(99, 0);
        if (sel < 20) op = op_beq;
        else if (sel < 45) op = op_addi;
        else if (sel < 62) op = op_add;
        else if (sel < 77) op = op_sub;
        else if (sel < 90) op = op_nop;
        else op = 3'($urandom_range(7, 5));   // undefined codes act as nop
        instr        = '0;
        instr[15:13] = op;
        instr[12:10] = pick_reg();
        instr[9:7]   = pick_reg();
        if (op == op_addi) instr[4:0] = 5'($urandom);
        else if (op == op_beq) instr[4:0] = branch_offset();
        else instr[6:4] = pick_reg();
        return instr;
    endfunction

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string what, input logic [xlen-1:0] got,
                               input logic [xlen-1:0] expected);
        if (got !== expected) begin
            fail_run($sformatf("CHECK FAILED at %0t ns: %s got 0x%0h expected 0x%0h",
                               $time, what, got, expected));
        end
    endtask

    // one instruction of the reference ISA, returning what its commit must show
    task automatic model_step(output logic [pc_width-1:0] pc, output logic w_v,
                              output logic [reg_addr_width-1:0] rd,
                              output logic [xlen-1:0] data);
        logic [instr_width-1:0]    instr;
        logic [reg_addr_width-1:0] rs1, rs2;
        logic [xlen-1:0]           a, b, imm;
        logic                      writes;
        instr    = rom[model_pc];
        rd       = instr[12:10];
        rs1      = instr[9:7];
        rs2      = instr[6:4];
        imm      = {{11{instr[4]}}, instr[4:0]};
        a        = model_rf[rs1];
        b        = model_rf[rs2];
        pc       = model_pc;
        model_pc = model_pc + 1;
        writes   = 1'b1;
        data     = '0;
        case (instr[15:13])
            op_add:  data = a + b;
            op_sub:  data = a - b;
            op_addi: data = a + imm;
            op_beq: begin
                writes = 1'b0;
                if (a == b) model_pc = pc + 1 + imm[7:0];
            end
            default: writes = 1'b0;
        endcase
        w_v = writes && rd != '0;
        if (w_v) model_rf[rd] = data;
    endtask

    task automatic wait_commit();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!cmt_v) begin
            if (u_dut.chk.fail_count != 0) begin
                fail_run("an assertion in core_chk failed");
            end else if (cycles == commit_timeout) begin
                fail_run($sformatf("timeout: no commit within %0d cycles at %0t ns",
                                   commit_timeout, $time));
            end else begin
                cycles++;
                @(negedge clk);
            end
        end
    endtask

    task automatic run_commits(input int count);
        logic [pc_width-1:0]       pc;
        logic                      w_v;
        logic [reg_addr_width-1:0] rd;
        logic [xlen-1:0]           data;
        for (int i = 0; i < count; i++) begin
            wait_commit();
            model_step(pc, w_v, rd, data);
            check_value("commit pc", xlen'(cmt_pc), xlen'(pc));
            check_value("commit rd_w_v", xlen'(cmt_rd_w_v), xlen'(w_v));
            if (w_v) begin
                check_value("commit rd", xlen'(cmt_rd_addr), xlen'(rd));
                check_value("commit data", cmt_data, data);
            end
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        reset <= 1'b1;
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;
        model_pc = '0;   // model restarts with the DUT
        for (int i = 0; i < num_regs; i++) model_rf[i] = '0;
    endtask

    initial begin
        reset = 1'b1;
        void'($urandom(2352));
        for (int addr = 0; addr < 2 ** pc_width; addr++) rom[addr] = make_instr();
        apply_reset();
        run_commits(commits_per_run);
        apply_reset();   // second pulse in the middle of a running program
        run_commits(commits_per_run);
        @(negedge clk);
        if (u_dut.chk.fail_count != 0) begin
            fail_run("an assertion in core_chk failed");
        end else begin
            $display("TEST PASSED");
            $finish;
        end
    end

endmodule : core_tb

//--- test/core_chk.sv
// concurrent assertions on reset, the redirect queue and register 0 reads, bound to core_top
`timescale 1ns/1ps

module core_chk
    import core_isa_pkg::*;
(
    input logic                      clk_i,
    input logic                      reset_i,
    input logic                      cmd_push_v_i,
    input logic                      cmd_ready_i,
    input logic                      cmt_v_i,
    input logic                      dec_v_i,
    input logic [reg_addr_width-1:0] rf_raddr0_i,
    input logic [reg_addr_width-1:0] rf_raddr1_i,
    input logic [xlen-1:0]           rf_rdata0_i,
    input logic [xlen-1:0]           rf_rdata1_i
);

    int unsigned fail_count = 0;

    // reset is synchronous, so the stage valids are low one cycle later
    commit_quiet_after_reset: assert property (
        @(posedge clk_i) reset_i |=> !cmt_v_i
    ) else begin
        $error("commit seen in the cycle after reset");
        fail_count++;
    end

    cmd_push_not_full: assert property (
        @(posedge clk_i) disable iff (reset_i) !(cmd_push_v_i && !cmd_ready_i)
    ) else begin
        $error("redirect pushed into a full command queue");
        fail_count++;
    end

    // operand reads are only meaningful while execute holds a valid entry
    r0_reads_zero: assert property (
        @(posedge clk_i) disable iff (reset_i)
            dec_v_i |-> (rf_raddr0_i != '0 || rf_rdata0_i == '0)
                     && (rf_raddr1_i != '0 || rf_rdata1_i == '0)
    ) else begin
        $error("register 0 read back a nonzero value");
        fail_count++;
    end

endmodule : core_chk

bind core_top core_chk chk (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .cmd_push_v_i(fe_cmd_v_li),
    .cmd_ready_i (fe_cmd_ready_lo),
    .cmt_v_i     (cmt_v_o),
    .dec_v_i     (dec_v),
    .rf_raddr0_i (rf_raddr0),
    .rf_raddr1_i (rf_raddr1),
    .rf_rdata0_i (rf_rdata0),
    .rf_rdata1_i (rf_rdata1)
);

//--- src/core_top.sv
// core top connecting the front end, both queues and the decode, execute and result stages
`timescale 1ns/1ps

module core_top
    import core_isa_pkg::*;
    import core_if_pkg::*;
(
    input  logic                      clk_i,
    input  logic                      reset_i,

    output logic [pc_width-1:0]       imem_addr_o,
    input  logic [instr_width-1:0]    imem_data_i,

    output logic                      cmt_v_o,
    output logic [pc_width-1:0]       cmt_pc_o,
    output logic                      cmt_rd_w_v_o,
    output logic [reg_addr_width-1:0] cmt_rd_addr_o,
    output logic [xlen-1:0]           cmt_data_o
);

    fe_queue_s fe_queue_li, fe_queue_lo;
    logic      fe_queue_v_li, fe_queue_ready_lo;
    logic      fe_queue_v_lo, fe_queue_yumi_li;
    logic      fe_queue_clr_li;

    fe_cmd_s   fe_cmd_li, fe_cmd_lo;
    logic      fe_cmd_v_li, fe_cmd_ready_lo;
    logic      fe_cmd_v_lo, fe_cmd_yumi_li;

    decoded_s  dec;
    logic      dec_v, squash;
    result_s   res;
    logic      res_v;

    logic [reg_addr_width-1:0] rf_raddr0, rf_raddr1;
    logic [xlen-1:0]           rf_rdata0, rf_rdata1;

    core_fe fe (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .imem_addr_o     (imem_addr_o),
        .imem_data_i     (imem_data_i),
        .fe_queue_o      (fe_queue_li),
        .fe_queue_v_o    (fe_queue_v_li),
        .fe_queue_ready_i(fe_queue_ready_lo),
        .fe_cmd_i        (fe_cmd_lo),
        .fe_cmd_v_i      (fe_cmd_v_lo),
        .fe_cmd_yumi_o   (fe_cmd_yumi_li)
    );

    core_fifo #(
        .payload_t(fe_queue_s),
        .els      (fe_queue_els)
    ) fe_queue_fifo (
        .clk_i  (clk_i),
        .reset_i(reset_i),
        .clr_i  (fe_queue_clr_li),   // flushed on a taken branch
        .data_i (fe_queue_li),
        .v_i    (fe_queue_v_li),
        .ready_o(fe_queue_ready_lo),
        .data_o (fe_queue_lo),
        .v_o    (fe_queue_v_lo),
        .yumi_i (fe_queue_yumi_li)
    );

    core_fifo #(
        .payload_t(fe_cmd_s),
        .els      (fe_cmd_els)
    ) fe_cmd_fifo (
        .clk_i  (clk_i),
        .reset_i(reset_i),
        .clr_i  (1'b0),
        .data_i (fe_cmd_li),
        .v_i    (fe_cmd_v_li),
        .ready_o(fe_cmd_ready_lo),
        .data_o (fe_cmd_lo),
        .v_o    (fe_cmd_v_lo),
        .yumi_i (fe_cmd_yumi_li)
    );

    core_be_decode decode (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .fe_queue_i     (fe_queue_lo),
        .fe_queue_v_i   (fe_queue_v_lo),
        .fe_queue_yumi_o(fe_queue_yumi_li),
        .squash_i       (squash),
        .dec_o          (dec),
        .dec_v_o        (dec_v)
    );

    core_be_execute execute (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .dec_i         (dec),
        .dec_v_i       (dec_v),
        .rf_raddr0_o   (rf_raddr0),
        .rf_raddr1_o   (rf_raddr1),
        .rf_rdata0_i   (rf_rdata0),
        .rf_rdata1_i   (rf_rdata1),
        .res_o         (res),
        .res_v_o       (res_v),
        .squash_o      (squash),
        .fe_queue_clr_o(fe_queue_clr_li),
        .fe_cmd_o      (fe_cmd_li),
        .fe_cmd_v_o    (fe_cmd_v_li),
        .fe_cmd_ready_i(fe_cmd_ready_lo)
    );

    core_be_result result (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .res_i        (res),
        .res_v_i      (res_v),
        .rf_raddr0_i  (rf_raddr0),
        .rf_raddr1_i  (rf_raddr1),
        .rf_rdata0_o  (rf_rdata0),
        .rf_rdata1_o  (rf_rdata1),
        .cmt_v_o      (cmt_v_o),
        .cmt_pc_o     (cmt_pc_o),
        .cmt_rd_w_v_o (cmt_rd_w_v_o),
        .cmt_rd_addr_o(cmt_rd_addr_o),
        .cmt_data_o   (cmt_data_o)
    );

endmodule : core_top

//--- src/core_be_result.sv
// result stage with the register file and registered commit trace
`timescale 1ns/1ps

module core_be_result
    import core_isa_pkg::*;
    import core_if_pkg::*;
(
    input  logic                      clk_i,
    input  logic                      reset_i,

    input  result_s                   res_i,
    input  logic                      res_v_i,

    input  logic [reg_addr_width-1:0] rf_raddr0_i,
    input  logic [reg_addr_width-1:0] rf_raddr1_i,
    output logic [xlen-1:0]           rf_rdata0_o,
    output logic [xlen-1:0]           rf_rdata1_o,

    output logic                      cmt_v_o,
    output logic [pc_width-1:0]       cmt_pc_o,
    output logic                      cmt_rd_w_v_o,
    output logic [reg_addr_width-1:0] cmt_rd_addr_o,
    output logic [xlen-1:0]           cmt_data_o
);

    logic [xlen-1:0] rf_q [num_regs];
    result_s         cmt_q;
    logic            cmt_v_q;

    assign rf_rdata0_o = rf_q[rf_raddr0_i];
    assign rf_rdata1_o = rf_q[rf_raddr1_i];

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < num_regs; i++) begin
                rf_q[i] <= '0;
            end
        end else if (res_v_i && res_i.w_v && res_i.rd != '0) begin
            rf_q[res_i.rd] <= res_i.value;   // entry 0 is never written
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            cmt_v_q <= 1'b0;
        end else begin
            cmt_v_q <= res_v_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (res_v_i) begin
            cmt_q <= res_i;
        end
    end

    assign cmt_v_o       = cmt_v_q;
    assign cmt_pc_o      = cmt_q.pc;
    assign cmt_rd_w_v_o  = cmt_q.w_v & (cmt_q.rd != '0);
    assign cmt_rd_addr_o = cmt_q.rd;
    assign cmt_data_o    = cmt_q.value;

endmodule : core_be_result

//--- src/core_be_execute.sv
// execute stage with operand bypass, ALU, branch resolution and redirect
`timescale 1ns/1ps

module core_be_execute
    import core_isa_pkg::*;
    import core_if_pkg::*;
(
    input  logic                      clk_i,
    input  logic                      reset_i,

    input  decoded_s                  dec_i,
    input  logic                      dec_v_i,

    output logic [reg_addr_width-1:0] rf_raddr0_o,
    output logic [reg_addr_width-1:0] rf_raddr1_o,
    input  logic [xlen-1:0]           rf_rdata0_i,
    input  logic [xlen-1:0]           rf_rdata1_i,

    output result_s                   res_o,
    output logic                      res_v_o,

    output logic                      squash_o,
    output logic                      fe_queue_clr_o,

    output fe_cmd_s                   fe_cmd_o,
    output logic                      fe_cmd_v_o,
    input  logic                      fe_cmd_ready_i
);

    result_s             res_q;
    logic                res_v_q;
    logic                byp_v, wr, taken;
    logic [xlen-1:0]     src0, src1, alu;
    logic [pc_width-1:0] target;

    assign rf_raddr0_o = dec_i.rs1;
    assign rf_raddr1_o = dec_i.rs2;

    // the register file sees this result only at the next edge
    assign byp_v = res_v_q & res_q.w_v & (res_q.rd != '0);
    assign src0  = (byp_v && res_q.rd == dec_i.rs1) ? res_q.value : rf_rdata0_i;
    assign src1  = (byp_v && res_q.rd == dec_i.rs2) ? res_q.value : rf_rdata1_i;

    always_comb begin
        alu = '0;
        wr  = 1'b0;
        case (dec_i.op)
            op_add: begin
                alu = src0 + src1;
                wr  = 1'b1;
            end
            op_sub: begin
                alu = src0 - src1;
                wr  = 1'b1;
            end
            op_addi: begin
                alu = src0 + dec_i.imm;
                wr  = 1'b1;
            end
            default: ;
        endcase
    end

    // the command queue holds at most one redirect per flush
    assign taken  = dec_v_i & (dec_i.op == op_beq) & (src0 == src1);
    assign target = dec_i.pc + pc_width'(1) + dec_i.imm[pc_width-1:0];

    assign squash_o       = taken;
    assign fe_queue_clr_o = taken;
    assign fe_cmd_v_o     = taken;
    assign fe_cmd_o.pc    = target;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            res_v_q <= 1'b0;
        end else begin
            res_v_q <= dec_v_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (dec_v_i) begin
            res_q.pc    <= dec_i.pc;
            res_q.rd    <= wr ? dec_i.rd : '0;
            res_q.w_v   <= wr;
            res_q.value <= alu;
        end
    end

    assign res_o   = res_q;
    assign res_v_o = res_v_q;

endmodule : core_be_execute

//--- src/core_be_decode.sv
// decode stage register that takes queue entries and splits them into fields
`timescale 1ns/1ps

module core_be_decode
    import core_isa_pkg::*;
    import core_if_pkg::*;
(
    input  logic      clk_i,
    input  logic      reset_i,

    input  fe_queue_s fe_queue_i,
    input  logic      fe_queue_v_i,
    output logic      fe_queue_yumi_o,

    input  logic      squash_i,

    output decoded_s  dec_o,
    output logic      dec_v_o
);

    decoded_s dec_n, dec_q;
    logic     dec_v_q;

    // execute never stalls, so an entry is taken whenever one is there
    assign fe_queue_yumi_o = fe_queue_v_i & ~squash_i;

    always_comb begin
        dec_n.pc  = fe_queue_i.pc;
        dec_n.rd  = fe_queue_i.instr[rd_lsb +: reg_addr_width];
        dec_n.rs1 = fe_queue_i.instr[rs1_lsb +: reg_addr_width];
        dec_n.rs2 = fe_queue_i.instr[rs2_lsb +: reg_addr_width];
        dec_n.imm = {{(xlen - imm_width){fe_queue_i.instr[imm_lsb + imm_width - 1]}},
                     fe_queue_i.instr[imm_lsb +: imm_width]};
        case (fe_queue_i.instr[op_lsb +: op_width])
            op_add:  dec_n.op = op_add;
            op_sub:  dec_n.op = op_sub;
            op_addi: dec_n.op = op_addi;
            op_beq:  dec_n.op = op_beq;
            default: dec_n.op = op_nop;   // undefined codes behave as nop
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i || squash_i) begin
            dec_v_q <= 1'b0;
        end else begin
            dec_v_q <= fe_queue_v_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (fe_queue_yumi_o) begin
            dec_q <= dec_n;
        end
    end

    assign dec_o   = dec_q;
    assign dec_v_o = dec_v_q;

endmodule : core_be_decode

//--- src/core_fe.sv
// front end holding the pc, fetching from instruction memory and applying redirects
`timescale 1ns/1ps

module core_fe
    import core_isa_pkg::*;
    import core_if_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   reset_i,

    output logic [pc_width-1:0]    imem_addr_o,
    input  logic [instr_width-1:0] imem_data_i,

    output fe_queue_s              fe_queue_o,
    output logic                   fe_queue_v_o,
    input  logic                   fe_queue_ready_i,

    input  fe_cmd_s                fe_cmd_i,
    input  logic                   fe_cmd_v_i,
    output logic                   fe_cmd_yumi_o
);

    logic [pc_width-1:0] pc_q;
    logic                push;

    assign imem_addr_o = pc_q;   // memory answers in the same cycle

    always_comb begin
        fe_queue_o.pc    = pc_q;
        fe_queue_o.instr = imem_data_i;
    end

    // a pending redirect suppresses fetch for that cycle
    assign fe_queue_v_o  = ~fe_cmd_v_i;
    assign fe_cmd_yumi_o = fe_cmd_v_i;

    assign push = fe_queue_v_o & fe_queue_ready_i;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pc_q <= '0;
        end else if (fe_cmd_v_i) begin
            pc_q <= fe_cmd_i.pc;
        end else if (push) begin
            pc_q <= pc_q + 1'b1;   // wraps at the top of the 8-bit space
        end
    end

endmodule : core_fe

//--- src/core_fifo.sv
// circular-buffer FIFO with valid/ready input, valid/yumi output and synchronous clear
`timescale 1ns/1ps

module core_fifo #(
    parameter type payload_t = logic,
    parameter int  els       = 2
) (
    input  logic     clk_i,
    input  logic     reset_i,
    input  logic     clr_i,

    input  payload_t data_i,
    input  logic     v_i,
    output logic     ready_o,

    output payload_t data_o,
    output logic     v_o,
    input  logic     yumi_i
);

    payload_t mem [els];

    logic [$clog2(els)-1:0]   wptr_q, rptr_q;
    logic [$clog2(els+1)-1:0] count_q;
    logic                     push, pop;

    assign ready_o = (count_q != els);
    assign v_o     = (count_q != '0);
    assign data_o  = mem[rptr_q];

    assign push = v_i & ready_o;
    assign pop  = yumi_i;   // consumer only raises yumi while v_o is high

    always_ff @(posedge clk_i) begin
        if (reset_i || clr_i) begin   // clear also drops a push in the same cycle
            wptr_q  <= '0;
            rptr_q  <= '0;
            count_q <= '0;
        end else begin
            if (push) begin
                wptr_q <= (wptr_q == els - 1) ? '0 : wptr_q + 1'b1;
            end
            if (pop) begin
                rptr_q <= (rptr_q == els - 1) ? '0 : rptr_q + 1'b1;
            end
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem[wptr_q] <= data_i;
        end
    end

endmodule : core_fifo

//--- src/core_if_pkg.sv
// structs passed between the front end and the back-end stages, and queue depths
package core_if_pkg;

    import core_isa_pkg::*;

    localparam int fe_queue_els = 4;
    localparam int fe_cmd_els   = 2;

    typedef struct packed {
        logic [pc_width-1:0]    pc;
        logic [instr_width-1:0] instr;
    } fe_queue_s;

    typedef struct packed {
        logic [pc_width-1:0] pc;   // redirect target
    } fe_cmd_s;

    typedef struct packed {
        logic [pc_width-1:0]       pc;
        op_e                       op;
        logic [reg_addr_width-1:0] rd;
        logic [reg_addr_width-1:0] rs1;
        logic [reg_addr_width-1:0] rs2;
        logic [xlen-1:0]           imm;   // already sign-extended
    } decoded_s;

    typedef struct packed {
        logic [pc_width-1:0]       pc;
        logic [reg_addr_width-1:0] rd;
        logic                      w_v;
        logic [xlen-1:0]           value;
    } result_s;

endpackage : core_if_pkg

//--- src/core_isa_pkg.sv
// opcode enum, instruction field positions and datapath widths
package core_isa_pkg;

    localparam int pc_width       = 8;
    localparam int instr_width    = 16;
    localparam int xlen           = 16;
    localparam int reg_addr_width = 3;
    localparam int num_regs       = 2 ** reg_addr_width;

    localparam int op_width  = 3;
    localparam int imm_width = 5;

    // lsb of each field, rs2 and imm5 overlap in bit 4
    localparam int op_lsb  = 13;
    localparam int rd_lsb  = 10;
    localparam int rs1_lsb = 7;
    localparam int rs2_lsb = 4;
    localparam int imm_lsb = 0;

    typedef enum logic [op_width-1:0] {
        op_nop  = 3'd0,
        op_add  = 3'd1,
        op_sub  = 3'd2,
        op_addi = 3'd3,
        op_beq  = 3'd4   // rd field is ignored
    } op_e;

endpackage : core_isa_pkg
